// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = bpf_engine_tb
FILELIST   = compile.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = *** TEST FAILED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/bpf_programs.svh
`ifndef BPF_PROGRAMS_SVH
`define BPF_PROGRAMS_SVH

localparam int N_TESTS = 20;
localparam int ROM_LEN = 66;

typedef logic [4:0] test_idx_t;  // Indexes TESTS
typedef logic [6:0] rom_idx_t;   // Indexes PROG_ROM

// How the expected ret_val is found
localparam logic [3:0] CK_NONE   = 4'd0;  // Taken from exp_ret as written
localparam logic [3:0] CK_W      = 4'd1;  // Big-endian word at off
localparam logic [3:0] CK_H      = 4'd2;
localparam logic [3:0] CK_B      = 4'd3;
localparam logic [3:0] CK_MSH    = 4'd4;  // 4*(P[off]&0xf)
localparam logic [3:0] CK_DIV    = 4'd5;  // Word at off / arg
localparam logic [3:0] CK_MOD    = 4'd6;
localparam logic [3:0] CK_CHAIN1 = 4'd7;  // ((w+17)*3 ^ 0xff00ff00) >> 4
localparam logic [3:0] CK_CHAIN2 = 4'd8;  // (((-w)<<2 | 5) & 0x0ffffff7) - 9

typedef struct packed {
    logic [7:0]  start;      // First instruction in PROG_ROM
    logic [7:0]  ninst;
    word_t       len;        // packet_len driven for the run
    word_t       exp_ret;
    logic        exp_fault;
    logic [3:0]  calc;
    logic [7:0]  off;        // Packet byte the check reads
    word_t       arg;
    logic [15:0] etype;      // Written to bytes 12..13 when non-zero
} test_t;

// Columns are code_jt_jf_k
localparam inst_t PROG_ROM [ROM_LEN] = '{
    64'h0006_00_00_0000002a,                                                 // RET #42
    64'h0020_00_00_00000006, 64'h0016_00_00_00000000,                        // ld [6]
    64'h0028_00_00_00000014, 64'h0016_00_00_00000000,                        // ldh [20]
    64'h0001_00_00_00000003, 64'h0050_00_00_0000000a, 64'h0016_00_00_00000000,
    64'h0001_00_00_00000002, 64'h0040_00_00_0000001e, 64'h0016_00_00_00000000,
    64'h0080_00_00_00000000, 64'h0016_00_00_00000000,                        // ld len
    64'h00b1_00_00_0000000e, 64'h0087_00_00_00000000, 64'h0016_00_00_00000000,
    // EtherType filter, IPv4 and len > 59 and len & 0x7c0
    64'h0028_00_00_0000000c, 64'h0015_00_04_00000800, 64'h0080_00_00_00000000,
    64'h0025_00_02_0000003b, 64'h0045_00_01_000007c0, 64'h0016_00_00_00000000,
    64'h0006_00_00_00000000,
    64'h0020_00_00_00000000, 64'h0034_00_00_00000007, 64'h0016_00_00_00000000,
    64'h0020_00_00_00000004, 64'h0001_00_00_000003e8, 64'h009c_00_00_00000000,
    64'h0016_00_00_00000000,
    64'h0020_00_00_00000008, 64'h0004_00_00_00000011, 64'h0024_00_00_00000003,
    64'h00a4_00_00_ff00ff00, 64'h0074_00_00_00000004, 64'h0016_00_00_00000000,
    64'h0020_00_00_00000028, 64'h0084_00_00_00000000, 64'h0064_00_00_00000002,
    64'h0044_00_00_00000005, 64'h0054_00_00_0ffffff7, 64'h0014_00_00_00000009,
    64'h0016_00_00_00000000,
    64'h0020_00_00_00000000, 64'h0001_00_00_00000000, 64'h003c_00_00_00000000,
    64'h0006_00_00_00000063,                                                 // Never reached
    // Scratch round trip through M[5] and M[11], JA skips a RET
    64'h0000_00_00_abcd1234, 64'h0007_00_00_00000000, 64'h0000_00_00_00001111,
    64'h0002_00_00_00000005, 64'h0003_00_00_0000000b, 64'h0005_00_00_00000001,
    64'h0006_00_00_00000001, 64'h0061_00_00_00000005, 64'h0060_00_00_0000000b,
    64'h000c_00_00_00000000, 64'h0016_00_00_00000000,
    64'h0000_00_00_00000005, 64'h000e_00_00_00000000, 64'h0016_00_00_00000000,
    64'h0000_00_00_00000005, 64'h0005_00_00_00000400, 64'h0016_00_00_00000000,  // Target 1026
    64'h0020_00_00_00000018, 64'h0016_00_00_00000000
};

// start, ninst, len, exp_ret, exp_fault, calc, off, arg, etype
localparam test_t TESTS [N_TESTS] = '{
    '{0,  1,  64,  42,  0, CK_NONE,   0,  0,    'h0000},
    '{1,  2,  64,  0,   0, CK_W,      6,  0,    'h0000},
    '{3,  2,  64,  0,   0, CK_H,      20, 0,    'h0000},
    '{5,  3,  64,  0,   0, CK_B,      13, 0,    'h0000},  // X=3 plus k=10
    '{8,  3,  64,  0,   0, CK_W,      32, 0,    'h0000},
    '{11, 2,  321, 321, 0, CK_NONE,   0,  0,    'h0000},
    '{13, 3,  64,  0,   0, CK_MSH,    14, 0,    'h0000},
    '{16, 7,  100, 100, 0, CK_NONE,   0,  0,    'h0800},
    '{16, 7,  100, 0,   0, CK_NONE,   0,  0,    'h86dd},  // Not IPv4
    '{16, 7,  40,  0,   0, CK_NONE,   0,  0,    'h0800},  // Too short
    '{16, 7,  60,  0,   0, CK_NONE,   0,  0,    'h0800},  // len & 0x7c0 clear
    '{23, 3,  64,  0,   0, CK_DIV,    0,  7,    'h0000},
    '{26, 4,  64,  0,   0, CK_MOD,    4,  1000, 'h0000},
    '{30, 6,  64,  0,   0, CK_CHAIN1, 8,  0,    'h0000},
    '{36, 7,  64,  0,   0, CK_CHAIN2, 40, 0,    'h0000},
    '{43, 4,  64,  0,   0, CK_NONE,   0,  0,    'h0000},  // Divide by zero drops
    '{47, 11, 64,  'habcd2345, 0, CK_NONE, 0, 0, 'h0000},
    '{58, 3,  64,  0,   1, CK_NONE,   0,  0,    'h0000},  // Undefined opcode
    '{61, 3,  64,  0,   1, CK_NONE,   0,  0,    'h0000},  // JA off the end
    '{64, 2,  64,  0,   0, CK_W,      24, 0,    'h0000}
};

`endif

// File: bench/bpf_engine_tb.sv
`timescale 1ns/1ns

module bpf_engine_tb
    import bpf_isa_pkg::*;
    import bpf_dp_pkg::*;
();

    localparam int CLK_PERIOD  = 4;
    localparam int RST_CYCLES  = 16;
    localparam int DRIVE_DELAY = 1;  // After the rising edge

    logic       clk;
    logic       rst;
    logic       start;
    word_t      packet_len;
    inst_t      inst_data = '0;
    word_t      packet_data = '0;
    logic       busy, done, fault;
    word_t      ret_val;
    code_addr_t inst_rd_addr;
    byte_addr_t packet_rd_addr;

    inst_t      imem [1 << CODE_ADDR_WIDTH];
    logic [7:0] pmem [1 << BYTE_ADDR_WIDTH];

    integer     seed;
    int         errors, n_pass, n_fail;
    logic       test_bad;   // Current test saw a mismatch
    logic       no_done;    // Engine stopped answering

    `include "bpf_programs.svh"

    bpf_engine u_bpf_engine (
        .clk, .rst, .start, .packet_len, .inst_data, .packet_data,
        .busy, .done, .ret_val, .fault, .inst_rd_addr, .packet_rd_addr
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Both memories answer one edge after the address
    always @(posedge clk) begin
        inst_data   <= imem[inst_rd_addr];
        packet_data <= {pmem[packet_rd_addr], pmem[packet_rd_addr + byte_addr_t'(1)],
                        pmem[packet_rd_addr + byte_addr_t'(2)],
                        pmem[packet_rd_addr + byte_addr_t'(3)]};
    end

    function automatic logic [7:0] pkt_byte(input int a);
        return pmem[byte_addr_t'(a)];
    endfunction

    function automatic word_t pkt_word(input int a);
        return {pkt_byte(a), pkt_byte(a + 1), pkt_byte(a + 2), pkt_byte(a + 3)};
    endfunction

    // Expected result from the packet image and the BPF rules
    function automatic word_t expected_ret(input test_t t);
        word_t      w;
        logic [7:0] b;
        w = pkt_word(int'(t.off));
        b = pkt_byte(int'(t.off));
        case (t.calc)
            CK_W:      return w;
            CK_H:      return w >> 16;                   // Top halfword
            CK_B:      return 32'(b);
            CK_MSH:    return 32'(b & 8'h0f) * 32'd4;
            CK_DIV:    return w / t.arg;
            CK_MOD:    return w % t.arg;
            CK_CHAIN1: return (((w + 32'd17) * 32'd3) ^ 32'hff00_ff00) >> 4;
            CK_CHAIN2: return ((((32'd0 - w) << 2) | 32'd5) & 32'h0fff_fff7) - 32'd9;
            default:   return t.exp_ret;
        endcase
    endfunction

    function automatic int longest_program();
        int n;
        n = 0;
        for (int i = 0; i < N_TESTS; i++)
            if (int'(TESTS[test_idx_t'(i)].ninst) > n)
                n = int'(TESTS[test_idx_t'(i)].ninst);
        return n;
    endfunction

    task automatic load_test(input test_t t);
        // Illegal MISC opcode everywhere else, k holds the address
        for (int a = 0; a < (1 << CODE_ADDR_WIDTH); a++)
            imem[code_addr_t'(a)] = {16'h00ff, 16'h0000, 22'h0, code_addr_t'(a)};
        for (int i = 0; i < int'(t.ninst); i++)
            imem[code_addr_t'(i)] = PROG_ROM[rom_idx_t'(int'(t.start) + i)];
        for (int b = 0; b < (1 << BYTE_ADDR_WIDTH); b++)
            pmem[byte_addr_t'(b)] = 8'($random(seed));
        if (t.etype != 16'h0000) begin
            pmem[12] = t.etype[15:8];  // EtherType field
            pmem[13] = t.etype[7:0];
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic run_test(input int idx);
        test_t t;
        word_t exp;
        int    limit;
        int    cycles;
        t        = TESTS[test_idx_t'(idx)];
        limit    = int'(t.ninst) * 40 + 20;
        test_bad = 1'b0;
        load_test(t);
        exp        = expected_ret(t);
        packet_len = t.len;
        start      = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY start = 1'b0;
        check_flag($sformatf("test %0d busy after start", idx), busy, 1'b1);
        cycles = 0;
        while (!done && cycles < limit) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
        if (!done) begin
            $display("test %0d: engine gave no done pulse within %0d cycles", idx, limit);
            no_done = 1'b1;
            n_fail++;
        end else begin
            check_word($sformatf("test %0d ret_val", idx), ret_val, exp);
            check_flag($sformatf("test %0d fault", idx), fault, t.exp_fault);
            @(posedge clk);  // Back in idle, results stay put
            #DRIVE_DELAY;
            check_flag($sformatf("test %0d done after pulse", idx), done, 1'b0);
            check_flag($sformatf("test %0d busy when idle", idx), busy, 1'b0);
            check_word($sformatf("test %0d ret_val held", idx), ret_val, exp);
            check_flag($sformatf("test %0d fault held", idx), fault, t.exp_fault);
            if (test_bad)
                n_fail++;
            else
                n_pass++;
            $display("test %0d: %s, ret_val %h fault %b after %0d cycles", idx,
                     test_bad ? "mismatch" : "ok", ret_val, fault, cycles);
        end
    endtask

    initial begin
        seed       = 32'h957f72e7;
        rst        = 1'b1;
        start      = 1'b0;
        packet_len = '0;
        errors     = 0;
        n_pass     = 0;
        n_fail     = 0;
        no_done    = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DELAY rst = 1'b0;
        for (int i = 0; i < N_TESTS && !no_done; i++)
            run_test(i);
        $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
                 n_pass + n_fail, n_pass, n_fail, errors);
        if (errors == 0 && !no_done && n_pass == N_TESTS)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // Worst case per test is 40 cycles an instruction plus slack
    initial begin
        int wd_ns;
        wd_ns = N_TESTS * (longest_program() * 40 + 20) * CLK_PERIOD;
        #(wd_ns);
        $display("Watchdog expired after %0d ns with tests still running", wd_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: compile.f
rtl/bpf_isa_pkg.sv
rtl/bpf_dp_pkg.sv
rtl/bpf_alu.sv
rtl/bpf_scratch.sv
rtl/bpf_datapath.sv
rtl/bpf_controller.sv
rtl/bpf_engine.sv
bench/bpf_engine_tb.sv
+incdir+bench

// File: rtl/bpf_alu.sv
`timescale 1ns/1ns

module bpf_alu
    import bpf_isa_pkg::*;
    import bpf_dp_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  word_t   a_val,
    input  word_t   b_val,
    input  alu_op_e alu_op,
    input  logic    alu_start,
    output word_t   alu_out,
    output logic    eq,
    output logic    gt,
    output logic    ge,
    output logic    set,
    output logic    alu_vld,
    output logic    div_zero
);

    word_t       quick_res;           // Result of the one-cycle ops
    word_t       quot_q, dsor_q;
    word_t       rem_q;
    logic [5:0]  cnt_q;               // Divide steps left
    logic        div_busy, is_mod_q;
    logic [32:0] rem_shift, rem_diff;
    word_t       quot_nxt, rem_nxt;
    logic        is_div;

    // Jump comparisons, A against K or X
    assign eq  = (a_val == b_val);
    assign gt  = (a_val > b_val);
    assign ge  = (a_val >= b_val);
    assign set = |(a_val & b_val);

    assign is_div = (alu_op == ALU_DIV) || (alu_op == ALU_MOD);

    always_comb begin
        case (alu_op)
            ALU_ADD: quick_res = a_val + b_val;
            ALU_SUB: quick_res = a_val - b_val;
            ALU_MUL: quick_res = a_val * b_val;  // Low 32 bits
            ALU_OR:  quick_res = a_val | b_val;
            ALU_AND: quick_res = a_val & b_val;
            ALU_XOR: quick_res = a_val ^ b_val;
            ALU_LSH: quick_res = a_val << b_val;
            ALU_RSH: quick_res = a_val >> b_val;
            ALU_NEG: quick_res = -a_val;
            default: quick_res = '0;             // DIV/MOD by zero give 0
        endcase
    end

    // One restoring step: shift in next dividend bit, try subtract
    assign rem_shift = {rem_q, quot_q[31]};
    assign rem_diff  = rem_shift - {1'b0, dsor_q};
    assign quot_nxt  = {quot_q[30:0], ~rem_diff[32]};
    assign rem_nxt   = rem_diff[32] ? rem_shift[31:0] : rem_diff[31:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_vld  <= 1'b0;
            div_zero <= 1'b0;
            div_busy <= 1'b0;
            cnt_q    <= '0;
        end else begin
            alu_vld  <= 1'b0;  // Both are pulses
            div_zero <= 1'b0;
            if (alu_start) begin
                if (is_div && b_val != '0) begin
                    div_busy <= 1'b1;
                    cnt_q    <= 6'd32;
                end else begin
                    alu_vld  <= 1'b1;
                    div_zero <= is_div;
                end
            end else if (div_busy) begin
                cnt_q <= cnt_q - 6'd1;
                if (cnt_q == 6'd1) begin  // Last step, result out next cycle
                    div_busy <= 1'b0;
                    alu_vld  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            quot_q   <= a_val;
            rem_q    <= '0;
            dsor_q   <= b_val;
            is_mod_q <= (alu_op == ALU_MOD);
            alu_out  <= quick_res;
        end else if (div_busy) begin
            quot_q <= quot_nxt;
            rem_q  <= rem_nxt;
            if (cnt_q == 6'd1)
                alu_out <= is_mod_q ? rem_nxt : quot_nxt;
        end
    end

    // Controller must wait out the divide before the next op
    a_no_start_in_div: assert property (@(posedge clk) disable iff (rst)
        div_busy |-> !alu_start);

endmodule

// File: rtl/bpf_controller.sv
`timescale 1ns/1ns

module bpf_controller
    import bpf_isa_pkg::*;
    import bpf_dp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  inst_t      inst_data,
    input  logic       eq,
    input  logic       gt,
    input  logic       ge,
    input  logic       set,
    input  logic       alu_vld,
    input  logic       div_zero,
    input  word_t      a_val,
    input  code_addr_t pc,
    output a_sel_e     a_sel,
    output logic       a_en,
    output x_sel_e     x_sel,
    output logic       x_en,
    output pc_sel_e    pc_sel,
    output logic       pc_en,
    output logic       pc_clr,
    output logic       addr_sel,
    output ld_size_e   ld_size,
    output logic       b_sel,
    output logic       scr_wr_en,
    output logic       scr_src_x,
    output word_t      k,
    output jmp_off_t   jt,
    output jmp_off_t   jf,
    output alu_op_e    alu_op,
    output logic       alu_start,
    output logic       busy,
    output logic       done,
    output word_t      ret_val,
    output logic       fault
);

    typedef enum logic [2:0] {IDLE, FETCH, DECODE, EXEC, WAIT_ALU, FINISH} state_e;

    state_e      state;
    inst_t       ir_q;
    inst_t       cur;                     // Live word in DECODE, latched after
    code_t       code;
    logic [2:0]  cls;
    logic        illegal, jmp_fault, exec_ok;
    logic        wr_a, wr_x;
    word_t       jmp_off;
    logic [32:0] jmp_target;

    // Packet address must go out in DECODE, before the latch
    assign cur  = (state == DECODE) ? inst_data : ir_q;
    assign code = cur[INST_CODE_LSB +: 16];
    assign jt   = cur[INST_JT_LSB +: 8];
    assign jf   = cur[INST_JF_LSB +: 8];
    assign k    = cur[31:0];
    assign cls  = code[2:0];

    assign b_sel     = code[3];           // SRC_K / SRC_X
    assign scr_src_x = (cls == CLS_STX);
    assign alu_op    = alu_op_e'(code[7:4]);

    always_comb begin
        a_sel    = A_SEL_ALU;
        x_sel    = X_SEL_A;
        pc_sel   = PC_PLUS_1;
        addr_sel = (code[7:5] == MODE_IND) ? ADDR_IND : ADDR_ABS;
        ld_size  = ld_size_e'(code[4:3]);
        wr_a     = (cls == CLS_LD);
        wr_x     = (cls == CLS_LDX);
        illegal  = 1'b0;
        case (cls)
            CLS_LD, CLS_LDX: begin
                case (code[7:5])
                    MODE_IMM: begin a_sel = A_SEL_IMM; x_sel = X_SEL_IMM; end
                    MODE_ABS, MODE_IND: begin
                        a_sel   = A_SEL_PKT;
                        x_sel   = X_SEL_PKT;
                        illegal = (code[4:3] == 2'h3);  // No such size
                    end
                    MODE_MEM: begin a_sel = A_SEL_MEM; x_sel = X_SEL_MEM; end
                    MODE_LEN: begin a_sel = A_SEL_LEN; x_sel = X_SEL_LEN; end
                    MODE_MSH: begin
                        x_sel   = X_SEL_MSH;
                        illegal = (cls == CLS_LD) || (code[4:3] != SIZE_B);
                    end
                    default: illegal = 1'b1;
                endcase
            end
            CLS_ST, CLS_STX: ;
            CLS_ALU: illegal = (code[7:4] > ALU_XOR);
            CLS_JMP: begin
                case (code[7:4])
                    JMP_JA:   pc_sel = PC_PLUS_K;
                    JMP_JEQ:  pc_sel = eq  ? PC_PLUS_JT : PC_PLUS_JF;
                    JMP_JGT:  pc_sel = gt  ? PC_PLUS_JT : PC_PLUS_JF;
                    JMP_JGE:  pc_sel = ge  ? PC_PLUS_JT : PC_PLUS_JF;
                    JMP_JSET: pc_sel = set ? PC_PLUS_JT : PC_PLUS_JF;
                    default:  illegal = 1'b1;
                endcase
            end
            CLS_RET: illegal = (code[4:3] != RVAL_K) && (code[4:3] != RVAL_A);
            default: begin  // MISC
                wr_a    = (code[7:3] == MISC_TXA);
                wr_x    = (code[7:3] == MISC_TAX);
                a_sel   = A_SEL_X;
                illegal = !wr_a && !wr_x;
            end
        endcase
    end

    // Target past the code space ends the run
    assign jmp_off    = (pc_sel == PC_PLUS_K)  ? k :
                        (pc_sel == PC_PLUS_JT) ? word_t'(jt) : word_t'(jf);
    assign jmp_target = 33'(pc) + 33'(jmp_off) + 33'd1;
    assign jmp_fault  = (cls == CLS_JMP) && (jmp_target >= 33'(1 << CODE_ADDR_WIDTH));
    assign exec_ok    = (state == EXEC) && !illegal && !jmp_fault;

    always_comb begin
        a_en      = exec_ok && wr_a;
        x_en      = exec_ok && wr_x;
        scr_wr_en = exec_ok && (cls == CLS_ST || cls == CLS_STX);
        alu_start = exec_ok && (cls == CLS_ALU);
        pc_en     = exec_ok && (cls != CLS_ALU) && (cls != CLS_RET);
        pc_clr    = (state == IDLE) && start;
        if (state == WAIT_ALU && alu_vld && !div_zero) begin
            a_en  = 1'b1;  // a_sel is ALU for this class
            pc_en = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            ret_val <= '0;
            fault   <= 1'b0;
        end else begin
            case (state)
                IDLE: if (start) begin
                    state   <= FETCH;
                    ret_val <= '0;
                    fault   <= 1'b0;
                end
                FETCH:  state <= DECODE;
                DECODE: state <= EXEC;
                EXEC: begin
                    if (illegal || jmp_fault) begin
                        fault   <= 1'b1;
                        ret_val <= '0;
                        state   <= FINISH;
                    end else if (cls == CLS_RET) begin
                        ret_val <= (code[4:3] == RVAL_A) ? a_val : k;
                        state   <= FINISH;
                    end else begin
                        state <= (cls == CLS_ALU) ? WAIT_ALU : FETCH;
                    end
                end
                WAIT_ALU: if (alu_vld)
                    state <= div_zero ? FINISH : FETCH;  // Divide by zero drops
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DECODE)
            ir_q <= inst_data;
    end

    assign busy = (state != IDLE);
    assign done = (state == FINISH);

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done);

endmodule

// File: rtl/bpf_datapath.sv
`timescale 1ns/1ns

module bpf_datapath
    import bpf_isa_pkg::*;
    import bpf_dp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  a_sel_e     a_sel,
    input  logic       a_en,
    input  x_sel_e     x_sel,
    input  logic       x_en,
    input  pc_sel_e    pc_sel,
    input  logic       pc_en,
    input  logic       pc_clr,
    input  logic       addr_sel,
    input  ld_size_e   ld_size,
    input  logic       b_sel,
    input  logic       scr_src_x,
    input  word_t      k,
    input  jmp_off_t   jt,
    input  jmp_off_t   jf,
    input  word_t      alu_out,
    input  word_t      scr_rdata,
    input  word_t      packet_data,
    input  word_t      packet_len,
    output code_addr_t pc,
    output byte_addr_t packet_rd_addr,
    output word_t      a_val,
    output word_t      b_val,
    output scr_addr_t  scr_addr,
    output word_t      scr_wdata
);

    word_t      a_q, x_q;
    code_addr_t pc_q;
    code_addr_t pc_inc;
    word_t      ind_addr;
    word_t      pkt_val;   // Loaded word, trimmed to size
    word_t      msh_val;

    assign ind_addr       = x_q + k;
    assign packet_rd_addr = (addr_sel == ADDR_IND) ? ind_addr[BYTE_ADDR_WIDTH-1:0]
                                                   : k[BYTE_ADDR_WIDTH-1:0];

    // Memory returns big-endian word at the byte, keep the top bytes
    always_comb begin
        case (ld_size)
            LD_H:    pkt_val = {16'b0, packet_data[31:16]};
            LD_B:    pkt_val = {24'b0, packet_data[31:24]};
            default: pkt_val = packet_data;
        endcase
    end

    assign msh_val = {26'b0, packet_data[27:24], 2'b00};  // 4*(P[k]&0xf)

    always_ff @(posedge clk) begin
        if (rst || pc_clr) begin
            a_q <= '0;  // A and X start each run at zero
        end else if (a_en) begin
            case (a_sel)
                A_SEL_IMM: a_q <= k;
                A_SEL_PKT: a_q <= pkt_val;
                A_SEL_MEM: a_q <= scr_rdata;
                A_SEL_LEN: a_q <= packet_len;
                A_SEL_MSH: a_q <= msh_val;
                A_SEL_ALU: a_q <= alu_out;
                default:   a_q <= x_q;  // TXA
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || pc_clr) begin
            x_q <= '0;
        end else if (x_en) begin
            case (x_sel)
                X_SEL_IMM: x_q <= k;
                X_SEL_PKT: x_q <= pkt_val;
                X_SEL_MEM: x_q <= scr_rdata;
                X_SEL_LEN: x_q <= packet_len;
                X_SEL_MSH: x_q <= msh_val;
                default:   x_q <= a_q;  // TAX
            endcase
        end
    end

    // Jumps are relative to the next instruction
    assign pc_inc = pc_q + code_addr_t'(1);

    always_ff @(posedge clk) begin
        if (rst || pc_clr) begin
            pc_q <= '0;
        end else if (pc_en) begin
            case (pc_sel)
                PC_PLUS_JT: pc_q <= pc_inc + code_addr_t'(jt);
                PC_PLUS_JF: pc_q <= pc_inc + code_addr_t'(jf);
                PC_PLUS_K:  pc_q <= pc_inc + k[CODE_ADDR_WIDTH-1:0];  // JA
                default:    pc_q <= pc_inc;
            endcase
        end
    end

    assign pc    = pc_q;
    assign a_val = a_q;
    assign b_val = (b_sel == B_SEL_X) ? x_q : k;

    assign scr_addr  = k[SCR_ADDR_WIDTH-1:0];
    assign scr_wdata = scr_src_x ? x_q : a_q;

endmodule

// File: rtl/bpf_dp_pkg.sv
package bpf_dp_pkg;

    localparam int CODE_ADDR_WIDTH = 10;
    localparam int BYTE_ADDR_WIDTH = 12;
    localparam int SCR_DEPTH       = 16;  // M[0..15]
    localparam int SCR_ADDR_WIDTH  = 4;

    typedef logic [CODE_ADDR_WIDTH-1:0] code_addr_t;
    typedef logic [BYTE_ADDR_WIDTH-1:0] byte_addr_t;
    typedef logic [SCR_ADDR_WIDTH-1:0]  scr_addr_t;

    // New value for A; ABS and IND both arrive as PKT
    typedef enum logic [2:0] {
        A_SEL_IMM, A_SEL_PKT, A_SEL_MEM, A_SEL_LEN, A_SEL_MSH, A_SEL_ALU, A_SEL_X
    } a_sel_e;

    typedef enum logic [2:0] {
        X_SEL_IMM, X_SEL_PKT, X_SEL_MEM, X_SEL_LEN, X_SEL_MSH, X_SEL_A
    } x_sel_e;

    typedef enum logic [1:0] {PC_PLUS_1, PC_PLUS_JT, PC_PLUS_JF, PC_PLUS_K} pc_sel_e;

    typedef enum logic [1:0] {LD_W, LD_H, LD_B} ld_size_e;

    // Values match the BPF ALU op field code[7:4]
    typedef enum logic [3:0] {
        ALU_ADD = 4'h0, ALU_SUB = 4'h1, ALU_MUL = 4'h2, ALU_DIV = 4'h3,
        ALU_OR  = 4'h4, ALU_AND = 4'h5, ALU_LSH = 4'h6, ALU_RSH = 4'h7,
        ALU_NEG = 4'h8, ALU_MOD = 4'h9, ALU_XOR = 4'ha
    } alu_op_e;

    localparam logic ADDR_ABS = 1'b0;  // Packet address is k
    localparam logic ADDR_IND = 1'b1;  // Packet address is X+k

    localparam logic B_SEL_K = 1'b0;
    localparam logic B_SEL_X = 1'b1;

endpackage

// File: rtl/bpf_engine.sv
`timescale 1ns/1ns

module bpf_engine
    import bpf_isa_pkg::*;
    import bpf_dp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  word_t      packet_len,
    input  inst_t      inst_data,
    input  word_t      packet_data,
    output logic       busy,
    output logic       done,
    output word_t      ret_val,
    output logic       fault,
    output code_addr_t inst_rd_addr,
    output byte_addr_t packet_rd_addr
);

    a_sel_e     a_sel;
    x_sel_e     x_sel;
    pc_sel_e    pc_sel;
    ld_size_e   ld_size;
    alu_op_e    alu_op;
    logic       a_en, x_en, pc_en, pc_clr;
    logic       addr_sel, b_sel, scr_wr_en, scr_src_x;
    logic       alu_start, alu_vld, div_zero;
    logic       eq, gt, ge, set;
    word_t      k, a_val, b_val, alu_out;
    word_t      scr_wdata, scr_rdata;
    jmp_off_t   jt, jf;
    code_addr_t pc;
    scr_addr_t  scr_addr;

    assign inst_rd_addr = pc;  // Fetch straight from PC

    bpf_controller u_controller (
        .clk, .rst, .start, .inst_data,
        .eq, .gt, .ge, .set, .alu_vld, .div_zero, .a_val, .pc,
        .a_sel, .a_en, .x_sel, .x_en, .pc_sel, .pc_en, .pc_clr,
        .addr_sel, .ld_size, .b_sel, .scr_wr_en, .scr_src_x,
        .k, .jt, .jf, .alu_op, .alu_start,
        .busy, .done, .ret_val, .fault
    );

    bpf_datapath u_datapath (
        .clk, .rst,
        .a_sel, .a_en, .x_sel, .x_en, .pc_sel, .pc_en, .pc_clr,
        .addr_sel, .ld_size, .b_sel, .scr_src_x,
        .k, .jt, .jf,
        .alu_out, .scr_rdata, .packet_data, .packet_len,
        .pc, .packet_rd_addr, .a_val, .b_val, .scr_addr, .scr_wdata
    );

    bpf_alu u_alu (
        .clk, .rst, .a_val, .b_val, .alu_op, .alu_start,
        .alu_out, .eq, .gt, .ge, .set, .alu_vld, .div_zero
    );

    bpf_scratch u_scratch (
        .clk, .rst, .scr_addr, .scr_wdata, .scr_wr_en, .scr_rdata
    );

endmodule

// File: rtl/bpf_isa_pkg.sv
package bpf_isa_pkg;

    typedef logic [31:0] word_t;     // Data word, A/X/M[] width
    typedef logic [63:0] inst_t;     // {code, jt, jf, k}
    typedef logic [15:0] code_t;
    typedef logic [7:0]  jmp_off_t;  // Conditional jump offset

    // Field positions inside inst_t
    localparam int INST_CODE_LSB = 48;
    localparam int INST_JT_LSB   = 40;
    localparam int INST_JF_LSB   = 32;

    // Class, code[2:0]
    localparam logic [2:0] CLS_LD   = 3'h0;
    localparam logic [2:0] CLS_LDX  = 3'h1;
    localparam logic [2:0] CLS_ST   = 3'h2;
    localparam logic [2:0] CLS_STX  = 3'h3;
    localparam logic [2:0] CLS_ALU  = 3'h4;
    localparam logic [2:0] CLS_JMP  = 3'h5;
    localparam logic [2:0] CLS_RET  = 3'h6;
    localparam logic [2:0] CLS_MISC = 3'h7;

    // Load size, code[4:3]
    localparam logic [1:0] SIZE_W = 2'h0;
    localparam logic [1:0] SIZE_H = 2'h1;
    localparam logic [1:0] SIZE_B = 2'h2;

    // Addressing mode, code[7:5]
    localparam logic [2:0] MODE_IMM = 3'h0;
    localparam logic [2:0] MODE_ABS = 3'h1;
    localparam logic [2:0] MODE_IND = 3'h2;
    localparam logic [2:0] MODE_MEM = 3'h3;
    localparam logic [2:0] MODE_LEN = 3'h4;
    localparam logic [2:0] MODE_MSH = 3'h5;

    localparam logic SRC_K = 1'b0;  // code[3] for ALU and JMP
    localparam logic SRC_X = 1'b1;

    localparam logic [1:0] RVAL_K = 2'h0;  // RET source, code[4:3]
    localparam logic [1:0] RVAL_A = 2'h2;

    localparam logic [4:0] MISC_TAX = 5'h00;  // code[7:3]
    localparam logic [4:0] MISC_TXA = 5'h10;

    // Jump operation, code[7:4]
    localparam logic [3:0] JMP_JA   = 4'h0;
    localparam logic [3:0] JMP_JEQ  = 4'h1;
    localparam logic [3:0] JMP_JGT  = 4'h2;
    localparam logic [3:0] JMP_JGE  = 4'h3;
    localparam logic [3:0] JMP_JSET = 4'h4;

endpackage

// File: rtl/bpf_scratch.sv
`timescale 1ns/1ns

module bpf_scratch
    import bpf_isa_pkg::*;
    import bpf_dp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  scr_addr_t scr_addr,
    input  word_t     scr_wdata,
    input  logic      scr_wr_en,
    output word_t     scr_rdata
);

    word_t mem [SCR_DEPTH];  // M[0..15]

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SCR_DEPTH; i++)
                mem[i] <= '0;
        end else if (scr_wr_en) begin
            mem[scr_addr] <= scr_wdata;  // ST / STX
        end
    end

    // LD/LDX MEM read the same cycle as the write would happen
    assign scr_rdata = mem[scr_addr];

    // Address comes from the latched k, must be clean on a store
    a_wr_addr_known: assert property (@(posedge clk) disable iff (rst)
        scr_wr_en |-> !$isunknown(scr_addr));

endmodule
